//--- Makefile
TOP = lms_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wall -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- include/lms_cfg.svh
`ifndef LMS_CFG_SVH
`define LMS_CFG_SVH

// Filter size
`define LMS_TAPS 8

// Word widths
`define LMS_SAMPLE_W 16
`define LMS_COEFF_W 17
`define LMS_MU_W 16

// Fraction handling
`define LMS_OUT_SHIFT 15   // Sum back to sample scale
`define LMS_STEP_SHIFT 30  // err * x * mu down to coefficient scale

// Clock cycles per sample, one per rate mode
// Kept small for simulation, each must stay >= 6
`define LMS_DIV0 12
`define LMS_DIV1 10

`endif

//--- tb.f
+incdir+include
verilog/lms_types_pkg.sv
verilog/lms_ctrl_pkg.sv
verilog/tap_bus_if.sv
verilog/frame_sequencer.sv
verilog/lms_tap.sv
verilog/error_combiner.sv
verilog/lms_filter_top.sv
tb/lms_sva.sv
tb/lms_tb.sv

//--- tb/lms_sva.sv
`default_nettype none

module lms_sva (
  input logic clk,
  input logic nrst,
  input logic load,
  input logic update,
  input logic valid_out
);
  timeunit 1ns;
  timeprecision 100ps;

  // Strobes are single cycle pulses
  a_load_pulse: assert property (@(posedge clk) disable iff (!nrst) load |=> !load)
    else $error("load held for more than one cycle");

  a_update_pulse: assert property (@(posedge clk) disable iff (!nrst) update |=> !update)
    else $error("update held for more than one cycle");

  // Update follows the E3 edge of a valid frame, three edges after the shift
  a_update_after_e3: assert property (@(posedge clk) disable iff (!nrst)
      update |-> valid_out && $past(load, 3))
    else $error("update outside the cycle after a valid frame result");

  // Divisors are at least 6
  a_load_spacing: assert property (@(posedge clk) disable iff (!nrst)
      load |-> !$past(load, 1) && !$past(load, 2) && !$past(load, 3)
               && !$past(load, 4) && !$past(load, 5))
    else $error("load within 5 cycles of the previous load");

endmodule

bind lms_filter_top lms_sva u_sva (
  .clk        (clk),
  .nrst       (nrst),
  .load       (bus.load),
  .update     (bus.update),
  .valid_out  (valid_out)
);

`default_nettype wire

//--- tb/lms_tb.sv
`default_nettype none

`include "lms_cfg.svh"

module lms_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYC    = 10;
  localparam int TOTAL_FRAMES = 491;  // Sum over all tests below
  localparam int DIV_MAX      = (`LMS_DIV0 > `LMS_DIV1) ? `LMS_DIV0 : `LMS_DIV1;
  localparam int TIMEOUT_CYC  = (3 * TOTAL_FRAMES * DIV_MAX) / 2 + RESET_CYC;

  logic        clk;
  logic        nrst;
  logic        mode;
  logic        valid_in;
  logic        mu_we;
  logic [15:0] mu_in;
  logic [15:0] u_in;
  logic [15:0] d_in;
  logic        valid_out;
  logic [15:0] out;

  integer seed;
  int     cyc, tmo_cnt, pass_cnt, fail_cnt, fail_start;
  int     valid_pol;  // 0 low, 1 high, 2 random, 3 toggle per frame
  bit     mu_rand, zero_chk, gap_on, gap_seen, frame_start, e3_now;
  int     flip_at, sw_cyc, last_edge, e3_count;
  logic   vo_prev;

  // Reference model state
  longint m_x [`LMS_TAPS];
  longint m_w [`LMS_TAPS];
  longint m_cnt, m_mu, m_mu_hold, p_out, exp_out, exp_valid;
  logic   m_mode_q, p_valid;
  int     pend;

  lms_filter_top u_dut (
    .clk       (clk),
    .nrst      (nrst),
    .mode      (mode),
    .valid_in  (valid_in),
    .mu_we     (mu_we),
    .mu_in     (mu_in),
    .u_in      (u_in),
    .d_in      (d_in),
    .valid_out (valid_out),
    .out       (out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic longint wrap(input longint v, input int bits);
    return (v <<< (64 - bits)) >>> (64 - bits);  // Keep low bits, sign extend
  endfunction

  task automatic check_value(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("[ERROR] %0d ns %s expected %0d got %0d", $time, name, expected, actual);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // One clock edge of the filter as the frame rules describe it
  task automatic model_edge();
    longint div_last, acc, y, e;
    logic   chg, stb;
    div_last = mode ? `LMS_DIV1 - 1 : `LMS_DIV0 - 1;
    chg      = (mode != m_mode_q);
    stb      = !chg && (m_cnt == div_last);
    m_mode_q = mode;
    m_cnt    = (chg || stb) ? 0 : m_cnt + 1;
    if (pend > 0) begin
      pend--;
      if (pend == 0) begin  // E3
        exp_out   = p_out;
        exp_valid = longint'(p_valid);
        e3_count++;
        e3_now = 1'b1;
      end
    end
    if (stb) begin
      m_mu = m_mu_hold;  // Write at this same edge is too late
      for (int i = `LMS_TAPS - 1; i > 0; i--)
        m_x[i] = m_x[i-1];
      m_x[0] = longint'($signed(u_in));
      acc = 0;
      for (int i = 0; i < `LMS_TAPS; i++)
        acc += m_w[i] * m_x[i];
      y = wrap(acc >>> `LMS_OUT_SHIFT, `LMS_SAMPLE_W);
      e = wrap(longint'($signed(d_in)) - y, `LMS_SAMPLE_W);
      if (valid_in) begin
        for (int i = 0; i < `LMS_TAPS; i++)
          m_w[i] = wrap(m_w[i] + ((e * m_x[i] * m_mu) >>> `LMS_STEP_SHIFT), `LMS_COEFF_W);
      end
      p_out       = y;
      p_valid     = valid_in;
      pend        = 3;
      frame_start = 1'b1;
    end
    if (mu_we)
      m_mu_hold = longint'(mu_in);
  endtask

  task automatic drive_inputs();
    u_in  = 16'($random(seed));
    d_in  = 16'($random(seed));
    mu_we = 1'b0;
    case (valid_pol)
      0:       valid_in = 1'b0;
      1:       valid_in = 1'b1;
      2:       valid_in = 1'($random(seed));  // Only the E0 value counts
      default: if (frame_start) valid_in = !valid_in;
    endcase
    frame_start = 1'b0;
    if (mu_rand && (($random(seed) & 7) == 0)) begin
      mu_we = 1'b1;
      mu_in = 16'($random(seed));
    end
    if (cyc == flip_at) begin
      mode   = !mode;
      sw_cyc = cyc + 1;  // Edge that sees the change
    end
  endtask

  task automatic step_cycle();
    longint div_now, exp_cyc;
    @(posedge clk);
    cyc++;
    e3_now = 1'b0;
    if (nrst)
      model_edge();
    #1;
    check_value("out", exp_out, longint'($signed(out)));
    check_value("valid_out", exp_valid, longint'(valid_out));
    if (zero_chk && e3_now)
      check_value("out (mu zero)", 0, longint'($signed(out)));
    if (gap_on && valid_out != vo_prev) begin
      if (gap_seen) begin
        div_now = mode ? `LMS_DIV1 : `LMS_DIV0;
        exp_cyc = (sw_cyc > last_edge - 3) ? sw_cyc + div_now + 3 : last_edge + div_now;
        check_value("valid_out edge cycle", exp_cyc, cyc);
      end
      gap_seen  = 1'b1;
      last_edge = cyc;
      if (($random(seed) & 3) == 0)
        flip_at = cyc + ($random(seed) & 1);  // Switch lands before the next E0
    end
    vo_prev = valid_out;
    drive_inputs();
  endtask

  task automatic run_frames(input int n);
    int target;
    target = e3_count + n;
    while (e3_count < target)
      step_cycle();
  endtask

  task automatic write_mu(input logic [15:0] val);
    mu_we = 1'b1;
    mu_in = val;
    step_cycle();
  endtask

  task automatic finish_test(input int num, input string name);
    $display("Test %0d %s finished with %0d errors", num, name, fail_cnt - fail_start);
    fail_start = fail_cnt;
  endtask

  // Stops a run whose frames never complete
  initial begin
    tmo_cnt = 0;
    while (tmo_cnt < TIMEOUT_CYC) begin
      @(posedge clk);
      tmo_cnt++;
    end
    $display("Timeout after %0d cycles, the frames did not complete", tmo_cnt);
    $display("Something failed");
    $finish;
  end

  initial begin
    seed = 32'hd3115013;
    nrst = 1'b0;
    mode = 1'b0;
    valid_in = 1'b0;
    mu_we = 1'b0;
    mu_in = '0;
    u_in = '0;
    d_in = '0;
    cyc = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    fail_start = 0;
    valid_pol = 0;
    {mu_rand, zero_chk, gap_on, gap_seen, frame_start, e3_now} = '0;
    flip_at = -1;
    sw_cyc = -100;
    last_edge = 0;
    e3_count = 0;
    vo_prev = 1'b0;
    for (int i = 0; i < `LMS_TAPS; i++) begin
      m_x[i] = 0;
      m_w[i] = 0;
    end
    {m_cnt, m_mu, m_mu_hold, p_out, exp_out, exp_valid} = '0;
    m_mode_q = 1'b0;
    p_valid = 1'b0;
    pend = 0;

    repeat (RESET_CYC) step_cycle();
    nrst = 1'b1;
    run_frames(1);
    finish_test(1, "reset state");

    valid_pol = 1;
    zero_chk = 1'b1;
    run_frames(40);
    zero_chk = 1'b0;
    write_mu(16'h2000);
    run_frames(10);
    finish_test(2, "filtering without adaptation");

    write_mu(16'($random(seed)));
    run_frames(200);
    finish_test(3, "adaptation");

    valid_pol = 2;
    write_mu(16'($random(seed)));
    run_frames(100);
    finish_test(4, "valid gating");

    valid_pol = 3;
    gap_on = 1'b1;
    run_frames(60);
    gap_on = 1'b0;
    flip_at = -1;
    finish_test(5, "rate modes");

    valid_pol = 1;
    mu_rand = 1'b1;
    run_frames(80);
    finish_test(6, "step-size timing");

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/error_combiner.sv
`default_nettype none

`include "lms_cfg.svh"

module error_combiner import lms_types_pkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  prod_t   prod [`LMS_TAPS],
  input  sample_t d_lat,
  input  logic    valid_lat,
  input  logic    frame_done,
  output sample_t out,
  output logic    valid_out,
  tap_bus_if.comb bus
);

  sum_t    sum;
  sample_t y_next;

  // Adder tree over all taps
  always_comb begin
    sum = '0;
    for (int i = 0; i < `LMS_TAPS; i++) begin
      sum = sum + sum_t'(prod[i]);
    end
  end

  assign y_next = sample_t'(sum >>> `LMS_OUT_SHIFT);  // Truncates, no saturation

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      out        <= '0;
      valid_out  <= 1'b0;
      bus.update <= 1'b0;
    end else begin
      bus.update <= frame_done && valid_lat;  // Only valid frames adapt
      if (frame_done) begin
        out       <= y_next;
        valid_out <= valid_lat;
      end
    end
  end

  // Error of this frame, used by the taps in the next cycle
  always_ff @(posedge clk) begin
    if (frame_done)
      bus.err <= d_lat - y_next;
  end

endmodule

`default_nettype wire

//--- verilog/frame_sequencer.sv
`default_nettype none

`include "lms_cfg.svh"

module frame_sequencer
  import lms_types_pkg::*;
  import lms_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  logic      mode,
  input  logic      valid_in,
  input  logic      mu_we,
  input  mu_t       mu_in,
  input  sample_t   u_in,
  input  sample_t   d_in,
  output sample_t   d_lat,
  output logic      valid_lat,
  output logic      frame_done,
  tap_bus_if.seq    bus
);

  localparam int DIV_MAX = (`LMS_DIV0 > `LMS_DIV1) ? `LMS_DIV0 : `LMS_DIV1;
  localparam int CNT_W   = $clog2(DIV_MAX);

  rate_mode_e       mode_sel;
  rate_mode_e       mode_q;
  logic             mode_chg;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] div_last;
  logic             rate_stb;
  mu_t              mu_hold;
  phase_e           phase;
  phase_e           phase_nxt;

  assign mode_sel = rate_mode_e'(mode);
  assign mode_chg = (mode_sel != mode_q);
  assign div_last = (mode_sel == RATE_B) ? CNT_W'(`LMS_DIV1 - 1) : CNT_W'(`LMS_DIV0 - 1);
  assign rate_stb = !mode_chg && (cnt == div_last);

  // Rate divider, restarts on a mode switch
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      cnt    <= '0;
      mode_q <= RATE_A;
    end else begin
      mode_q <= mode_sel;
      if (mode_chg || rate_stb)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

  // Step size is held here and only copied to the bus at the frame start
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      mu_hold   <= '0;
      bus.mu    <= '0;
      valid_lat <= 1'b0;
    end else begin
      if (mu_we)
        mu_hold <= mu_in;
      if (rate_stb) begin
        bus.mu    <= mu_hold;
        valid_lat <= valid_in;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rate_stb) begin
      bus.x_new <= u_in;
      d_lat     <= d_in;
    end
  end

  always_comb begin
    phase_nxt = phase;
    unique case (phase)
      PH_IDLE:  if (rate_stb) phase_nxt = PH_SHIFT;
      PH_SHIFT: phase_nxt = PH_MULT;
      PH_MULT:  phase_nxt = PH_SUM;
      PH_SUM:   phase_nxt = PH_ADAPT;
      PH_ADAPT: phase_nxt = PH_IDLE;
      default:  phase_nxt = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst)
      phase <= PH_IDLE;
    else
      phase <= phase_nxt;
  end

  assign bus.load   = (phase == PH_SHIFT);  // Taps shift at the next edge
  assign frame_done = (phase == PH_SUM);    // Products are settled

endmodule

`default_nettype wire

//--- verilog/lms_ctrl_pkg.sv
`default_nettype none

package lms_ctrl_pkg;

  // Sample rate selection, picks the divisor
  typedef enum logic {
    RATE_A = 1'b0,
    RATE_B = 1'b1
  } rate_mode_e;

  // Frame phases, one clock each after the rate strobe
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_SHIFT,
    PH_MULT,
    PH_SUM,
    PH_ADAPT
  } phase_e;

endpackage

`default_nettype wire

//--- verilog/lms_filter_top.sv
`default_nettype none

`include "lms_cfg.svh"

module lms_filter_top import lms_types_pkg::*; (
  input  logic                     clk,
  input  logic                     nrst,
  input  logic                     mode,
  input  logic                     valid_in,
  input  logic                     mu_we,
  input  logic [`LMS_MU_W-1:0]     mu_in,
  input  logic [`LMS_SAMPLE_W-1:0] u_in,
  input  logic [`LMS_SAMPLE_W-1:0] d_in,
  output logic                     valid_out,
  output logic [`LMS_SAMPLE_W-1:0] out
);

  tap_bus_if bus ();

  sample_t d_lat;
  logic    valid_lat;
  logic    frame_done;
  sample_t x_chain [`LMS_TAPS];
  prod_t   prods   [`LMS_TAPS];

  frame_sequencer u_seq (
    .clk        (clk),
    .nrst       (nrst),
    .mode       (mode),
    .valid_in   (valid_in),
    .mu_we      (mu_we),
    .mu_in      (mu_in),
    .u_in       (u_in),
    .d_in       (d_in),
    .d_lat      (d_lat),
    .valid_lat  (valid_lat),
    .frame_done (frame_done),
    .bus        (bus.seq)
  );

  // Delay line, tap 0 is fed from the bus
  for (genvar i = 0; i < `LMS_TAPS; i++) begin : g_tap
    sample_t x_prev;
    if (i == 0) begin : g_first
      assign x_prev = bus.x_new;
    end else begin : g_next
      assign x_prev = x_chain[i-1];
    end

    lms_tap u_tap (
      .clk    (clk),
      .nrst   (nrst),
      .x_prev (x_prev),
      .x_out  (x_chain[i]),
      .prod   (prods[i]),
      .bus    (bus.tap)
    );
  end

  error_combiner u_comb (
    .clk        (clk),
    .nrst       (nrst),
    .prod       (prods),
    .d_lat      (d_lat),
    .valid_lat  (valid_lat),
    .frame_done (frame_done),
    .out        (out),
    .valid_out  (valid_out),
    .bus        (bus.comb)
  );

endmodule

`default_nettype wire

//--- verilog/lms_tap.sv
`default_nettype none

`include "lms_cfg.svh"

module lms_tap import lms_types_pkg::*; (
  input  logic    clk,
  input  logic    nrst,
  input  sample_t x_prev,
  output sample_t x_out,
  output prod_t   prod,
  tap_bus_if.tap  bus
);

  localparam int EX_W   = 2 * `LMS_SAMPLE_W;
  localparam int STEP_W = EX_W + `LMS_MU_W + 1;  // mu gets a zero sign bit

  coeff_t                    coeff;
  logic                      mult_en;
  logic signed [EX_W-1:0]    err_x;
  logic signed [STEP_W-1:0]  step_full;

  // LMS step, err * x * mu at full precision
  assign err_x     = bus.err * x_out;
  assign step_full = err_x * $signed({1'b0, bus.mu});

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      x_out   <= '0;
      coeff   <= '0;
      mult_en <= 1'b0;
    end else begin
      mult_en <= bus.load;
      if (bus.load)
        x_out <= x_prev;
      if (bus.update)
        coeff <= coeff + coeff_t'(step_full >>> `LMS_STEP_SHIFT);  // Wraps
    end
  end

  // Product one cycle after the shift
  always_ff @(posedge clk) begin
    if (mult_en)
      prod <= coeff * x_out;
  end

endmodule

`default_nettype wire

//--- verilog/lms_types_pkg.sv
`default_nettype none

`include "lms_cfg.svh"

package lms_types_pkg;

  localparam int PROD_W = `LMS_COEFF_W + `LMS_SAMPLE_W;
  localparam int SUM_W  = PROD_W + $clog2(`LMS_TAPS);  // Room for all taps

  // Audio sample, two's complement
  typedef logic signed [`LMS_SAMPLE_W-1:0] sample_t;

  // Filter coefficient
  typedef logic signed [`LMS_COEFF_W-1:0] coeff_t;

  // Step size is never negative
  typedef logic [`LMS_MU_W-1:0] mu_t;

  // Coefficient times sample, full precision
  typedef logic signed [PROD_W-1:0] prod_t;

  // Sum over the whole delay line
  typedef logic signed [SUM_W-1:0] sum_t;

endpackage

`default_nettype wire

//--- verilog/tap_bus_if.sv
`default_nettype none

`include "lms_cfg.svh"

interface tap_bus_if import lms_types_pkg::*; ();

  logic    load;    // Shift strobe, one cycle
  sample_t x_new;   // Sample entering the delay line
  mu_t     mu;      // Step size of the current frame
  logic    update;  // Adapt strobe, one cycle
  sample_t err;     // Error of the current frame

  modport seq (
    output load,
    output x_new,
    output mu
  );

  // Tap 0 gets x_new through the top level wiring
  modport tap (
    input load,
    input mu,
    input update,
    input err
  );

  modport comb (
    output update,
    output err
  );

endinterface

`default_nettype wire
